// File: source/ccu_config.svh
// ********************
// Width and size macros for the communications unit
// Include wherever a width or a depth is needed
// ********************
`ifndef CCU_CONFIG_SVH
`define CCU_CONFIG_SVH

`define CCU_ADDR_WIDTH      32
`define CCU_DATA_WIDTH      32
`define CCU_LINE_SIZE       16
`define CCU_LINE_WIDTH      128

`define CCU_MHQ_DEPTH       4
`define CCU_MHQ_IDX_WIDTH   2

`define CCU_WB_DATA_WIDTH   16
`define CCU_WB_SEL_WIDTH    2
`define CCU_WB_BEATS        8
`define CCU_WB_CTI_WIDTH    3
`define CCU_WB_BTE_WIDTH    2

`endif

// File: source/ccu_pkg.sv
// ********************
// Shared types for the communications unit
// Opcodes, FSM states, Wishbone encodings and the bundled port structs
// ********************
`include "ccu_config.svh"

package ccu_pkg;

    typedef enum logic [2:0] {
        OP_LB = 3'b000,
        OP_LH = 3'b001,
        OP_LW = 3'b010,
        OP_SB = 3'b100,
        OP_SH = 3'b101,
        OP_SW = 3'b110
    } ccu_op_e;                                         // Bit 2 marks a store

    typedef enum logic [1:0] {MHQ_IDLE, MHQ_FETCH, MHQ_FILL} ccu_mhq_state_e;
    typedef enum logic [1:0] {BIU_IDLE, BIU_BURST, BIU_DONE} ccu_biu_state_e;

    // Wishbone B4 cycle type and burst type
    localparam logic [`CCU_WB_CTI_WIDTH-1:0] CTI_INCR   = 3'b010;
    localparam logic [`CCU_WB_CTI_WIDTH-1:0] CTI_END    = 3'b111;
    localparam logic [`CCU_WB_BTE_WIDTH-1:0] BTE_LINEAR = 2'b00;

    typedef struct packed {
        logic                          valid;
        logic                          dc_hit;
        logic [`CCU_ADDR_WIDTH-1:0]    addr;
        ccu_op_e                       op;
        logic [`CCU_DATA_WIDTH-1:0]    data;            // Low-justified store bytes
    } ccu_lookup_t;

    typedef struct packed {
        logic                          retry;
        logic                          replay;
        logic [`CCU_MHQ_IDX_WIDTH-1:0] tag;
    } ccu_lookup_rsp_t;

    typedef struct packed {
        logic                          en;
        logic [`CCU_MHQ_IDX_WIDTH-1:0] tag;
        logic                          dirty;
        logic [`CCU_ADDR_WIDTH-1:0]    addr;
        logic [`CCU_LINE_WIDTH-1:0]    data;
    } ccu_fill_t;

    typedef struct packed {
        logic                          en;
        logic [`CCU_ADDR_WIDTH-1:0]    addr;            // Line aligned
    } ccu_biu_req_t;

    typedef struct packed {
        logic                          done;
        logic [`CCU_LINE_WIDTH-1:0]    data;
    } ccu_biu_rsp_t;

    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic                          we;
        logic [`CCU_WB_CTI_WIDTH-1:0]  cti;
        logic [`CCU_WB_BTE_WIDTH-1:0]  bte;
        logic [`CCU_WB_SEL_WIDTH-1:0]  sel;
        logic [`CCU_ADDR_WIDTH-1:0]    addr;
        logic [`CCU_WB_DATA_WIDTH-1:0] data;
    } ccu_wb_m2s_t;

    typedef struct packed {
        logic                          ack;
        logic [`CCU_WB_DATA_WIDTH-1:0] data;
    } ccu_wb_s2m_t;

endpackage

// File: source/ccu_mhq.sv
`timescale 1ns/1ps
// ********************
// Miss handling queue for the data cache
// Allocates or merges one line entry per miss and gathers store bytes
// Requests the oldest line from the BIU and emits a merged fill pulse
// ********************
`include "ccu_config.svh"

module ccu_mhq (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  ccu_pkg::ccu_lookup_t     i_lookup,
    output ccu_pkg::ccu_lookup_rsp_t o_lookup_rsp,
    output ccu_pkg::ccu_fill_t       o_fill,
    output ccu_pkg::ccu_biu_req_t    o_biu_req,
    input  ccu_pkg::ccu_biu_rsp_t    i_biu_rsp
);

    localparam int DEPTH     = `CCU_MHQ_DEPTH;
    localparam int IDX_W     = `CCU_MHQ_IDX_WIDTH;
    localparam int ADDR_W    = `CCU_ADDR_WIDTH;
    localparam int DATA_W    = `CCU_DATA_WIDTH;
    localparam int LINE_SIZE = `CCU_LINE_SIZE;
    localparam int LINE_W    = `CCU_LINE_WIDTH;
    localparam int OFFSET_W  = $clog2(LINE_SIZE);

    // Per-entry state
    logic [DEPTH-1:0]     ent_valid;
    logic [DEPTH-1:0]     ent_fetching;
    logic [DEPTH-1:0]     ent_dirty;
    logic [ADDR_W-1:0]    ent_addr [DEPTH];
    logic [LINE_SIZE-1:0] ent_mask [DEPTH];
    logic [LINE_W-1:0]    ent_line [DEPTH];

    // Allocation order with the oldest in slot 0
    logic [IDX_W-1:0]     age_q [DEPTH];
    logic [IDX_W:0]       age_count;
    logic [IDX_W:0]       push_slot;
    logic [IDX_W-1:0]     head;

    ccu_pkg::ccu_mhq_state_e  state_q;
    ccu_pkg::ccu_mhq_state_e  state_d;
    ccu_pkg::ccu_lookup_rsp_t rsp_q;

    logic [ADDR_W-1:0]    lk_line;
    logic [OFFSET_W-1:0]  lk_offset;
    logic                 act;
    logic                 is_store;
    logic                 hit;
    logic [IDX_W-1:0]     hit_idx;
    logic                 free_found;
    logic [IDX_W-1:0]     free_idx;
    logic                 retry;
    logic                 accept;
    logic                 alloc;
    logic [IDX_W-1:0]     acc_idx;
    logic [3:0]           st_base;
    logic [LINE_SIZE-1:0] st_mask;
    logic [LINE_W-1:0]    st_line;

    logic                 fill_now;
    logic                 issue;
    logic [LINE_W-1:0]    merged;
    logic                 biu_en_q;
    logic [ADDR_W-1:0]    biu_addr_q;
    logic                 fill_en_q;
    logic [IDX_W-1:0]     fill_tag_q;
    logic                 fill_dirty_q;
    logic [ADDR_W-1:0]    fill_addr_q;
    logic [LINE_W-1:0]    fill_data_q;

    // ********************
    // Lookup compare and allocation
    assign act       = i_lookup.valid && !i_lookup.dc_hit;
    assign lk_line   = {i_lookup.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign lk_offset = i_lookup.addr[OFFSET_W-1:0];
    assign is_store  = i_lookup.op inside {ccu_pkg::OP_SB, ccu_pkg::OP_SH, ccu_pkg::OP_SW};

    always_comb begin
        hit        = 1'b0;
        hit_idx    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int e = DEPTH - 1; e >= 0; e--) begin          // Lowest index wins
            if (ent_valid[e] && (ent_addr[e] == lk_line)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(e);
            end
            if (!ent_valid[e]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(e);
            end
        end
    end

    assign fill_now = (state_q == ccu_pkg::MHQ_FETCH) && i_biu_rsp.done;
    // A hit on the line leaving this cycle must come back later
    assign retry    = act && ((!hit && !free_found) || (hit && fill_now && hit_idx == head));
    assign accept   = act && !retry;
    assign alloc    = accept && !hit;
    assign acc_idx  = hit ? hit_idx : free_idx;

    always_comb begin
        case (i_lookup.op)
            ccu_pkg::OP_SB: st_base = 4'b0001;
            ccu_pkg::OP_SH: st_base = 4'b0011;
            ccu_pkg::OP_SW: st_base = 4'b1111;
            default:        st_base = 4'b0000;              // Loads write nothing
        endcase
    end

    assign st_mask = {{(LINE_SIZE - 4){1'b0}}, st_base} << lk_offset;
    assign st_line = {{(LINE_W - DATA_W){1'b0}}, i_lookup.data} << {lk_offset, 3'b000};

    // ********************
    // Fetch and fill FSM
    assign head      = age_q[0];
    assign push_slot = fill_now ? age_count - 1'b1 : age_count;
    assign issue     = (state_q != ccu_pkg::MHQ_FETCH) && (age_count != '0) && !ent_fetching[head];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::MHQ_IDLE:  if (issue) state_d = ccu_pkg::MHQ_FETCH;
            ccu_pkg::MHQ_FETCH: if (i_biu_rsp.done) state_d = ccu_pkg::MHQ_FILL;
            ccu_pkg::MHQ_FILL:  state_d = issue ? ccu_pkg::MHQ_FETCH : ccu_pkg::MHQ_IDLE;
            default:            state_d = ccu_pkg::MHQ_IDLE;
        endcase
    end

    always_comb begin
        for (int b = 0; b < LINE_SIZE; b++) begin
            merged[b*8 +: 8] = ent_mask[head][b] ? ent_line[head][b*8 +: 8]
                                                 : i_biu_rsp.data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q      <= ccu_pkg::MHQ_IDLE;
            ent_valid    <= '0;
            ent_fetching <= '0;
            ent_dirty    <= '0;
            age_count    <= '0;
            biu_en_q     <= 1'b0;
            fill_en_q    <= 1'b0;
            rsp_q        <= '0;
        end else begin
            state_q      <= state_d;
            age_count    <= age_count + {{IDX_W{1'b0}}, alloc} - {{IDX_W{1'b0}}, fill_now};
            fill_en_q    <= fill_now;
            rsp_q.retry  <= retry;
            rsp_q.replay <= accept && !is_store;
            rsp_q.tag    <= accept ? acc_idx : '0;
            if (issue) begin
                biu_en_q           <= 1'b1;
                ent_fetching[head] <= 1'b1;
            end else if (i_biu_rsp.done) begin
                biu_en_q <= 1'b0;
            end
            if (alloc) begin
                ent_valid[acc_idx]    <= 1'b1;
                ent_fetching[acc_idx] <= 1'b0;
                ent_dirty[acc_idx]    <= is_store;
            end else if (accept && is_store) begin
                ent_dirty[acc_idx] <= 1'b1;
            end
            if (fill_now) begin                              // Entry frees with the fill
                ent_valid[head]    <= 1'b0;
                ent_fetching[head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) biu_addr_q <= ent_addr[head];
        if (fill_now) begin
            fill_tag_q   <= head;
            fill_dirty_q <= ent_dirty[head];
            fill_addr_q  <= ent_addr[head];
            fill_data_q  <= merged;
        end
        if (alloc) begin
            ent_addr[acc_idx] <= lk_line;
            ent_mask[acc_idx] <= st_mask;
        end else if (accept) begin
            ent_mask[acc_idx] <= ent_mask[acc_idx] | st_mask;
        end
        for (int e = 0; e < DEPTH; e++) begin
            for (int b = 0; b < LINE_SIZE; b++) begin
                if (accept && acc_idx == IDX_W'(e) && st_mask[b]) begin
                    ent_line[e][b*8 +: 8] <= st_line[b*8 +: 8];
                end
            end
        end
        if (fill_now) begin
            for (int i = 0; i < DEPTH - 1; i++) age_q[i] <= age_q[i+1];
        end
        if (alloc) age_q[push_slot[IDX_W-1:0]] <= acc_idx;  // Overrides shift
    end

    assign o_lookup_rsp = rsp_q;
    assign o_biu_req    = '{en: biu_en_q, addr: biu_addr_q};
    assign o_fill       = '{en: fill_en_q, tag: fill_tag_q, dirty: fill_dirty_q,
                            addr: fill_addr_q, data: fill_data_q};

    // ********************
    // Checks
    a_rsp_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_lookup_rsp.retry && o_lookup_rsp.replay));
    a_fill_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_fill.en |=> !o_fill.en);
    a_req_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_biu_req.en && !i_biu_rsp.done |=> o_biu_req.en && $stable(o_biu_req.addr));

endmodule

// File: source/ccu_biu_wb.sv
`timescale 1ns/1ps
// ********************
// Bus interface unit for line fetches
// Turns one line request into an 8 beat Wishbone incrementing burst read
// and pulses done once the line is assembled
// ********************
`include "ccu_config.svh"

module ccu_biu_wb (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  ccu_pkg::ccu_biu_req_t i_biu_req,
    output ccu_pkg::ccu_biu_rsp_t o_biu_rsp,
    output ccu_pkg::ccu_wb_m2s_t  o_wb,
    input  ccu_pkg::ccu_wb_s2m_t  i_wb
);

    localparam int ADDR_W     = `CCU_ADDR_WIDTH;
    localparam int LINE_W     = `CCU_LINE_WIDTH;
    localparam int WB_DW      = `CCU_WB_DATA_WIDTH;
    localparam int BEATS      = `CCU_WB_BEATS;
    localparam int BEAT_W     = $clog2(BEATS);
    localparam int BYTE_SHIFT = $clog2(`CCU_WB_SEL_WIDTH);

    ccu_pkg::ccu_biu_state_e state_q;
    ccu_pkg::ccu_biu_state_e state_d;

    logic [BEAT_W-1:0] beat_q;
    logic [ADDR_W-1:0] base_q;
    logic [LINE_W-1:0] line_q;
    logic              in_burst;
    logic              beat_ack;
    logic              last_beat;

    assign in_burst  = state_q == ccu_pkg::BIU_BURST;
    assign beat_ack  = in_burst && i_wb.ack;
    assign last_beat = beat_q == BEAT_W'(BEATS - 1);

    // ********************
    // Burst FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::BIU_IDLE: begin
                if (i_biu_req.en) state_d = ccu_pkg::BIU_BURST;
            end
            ccu_pkg::BIU_BURST: begin
                if (beat_ack && last_beat) state_d = ccu_pkg::BIU_DONE;
            end
            ccu_pkg::BIU_DONE: begin
                state_d = ccu_pkg::BIU_IDLE;                 // One cycle done
            end
            default: begin
                state_d = ccu_pkg::BIU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ccu_pkg::BIU_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ccu_pkg::BIU_IDLE) begin
                beat_q <= '0;
            end else if (beat_ack) begin
                beat_q <= beat_q + 1'b1;                     // Wraps after last beat
            end
        end
    end

    // Line address and returned data
    always_ff @(posedge clk) begin
        if (state_q == ccu_pkg::BIU_IDLE && i_biu_req.en) begin
            base_q <= i_biu_req.addr;
        end
        if (beat_ack) begin
            line_q <= {i_wb.data, line_q[LINE_W-1:WB_DW]};   // Beat 0 ends up lowest
        end
    end

    // ********************
    // Outputs
    always_comb begin
        o_wb.cyc  = in_burst;
        o_wb.stb  = in_burst;
        o_wb.we   = 1'b0;
        o_wb.cti  = last_beat ? ccu_pkg::CTI_END : ccu_pkg::CTI_INCR;
        o_wb.bte  = ccu_pkg::BTE_LINEAR;
        o_wb.sel  = '1;
        o_wb.addr = base_q + (ADDR_W'(beat_q) << BYTE_SHIFT);
        o_wb.data = '0;                                      // Reads only
    end

    assign o_biu_rsp.done = state_q == ccu_pkg::BIU_DONE;
    assign o_biu_rsp.data = line_q;

    // ********************
    // Checks
    a_cyc_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb.cyc && !(i_wb.ack && o_wb.cti == ccu_pkg::CTI_END) |=> o_wb.cyc && o_wb.stb);
    a_addr_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb.stb && !i_wb.ack |=> o_wb.stb && $stable(o_wb.addr));

endmodule

// File: source/ccu_top.sv
`timescale 1ns/1ps
// ********************
// Communications unit top level
// Joins the miss handling queue to the Wishbone bus interface unit
// ********************

module ccu_top (
    input  logic                     clk,
    input  logic                     i_arst_n,

    // Cache lookup and fill
    input  ccu_pkg::ccu_lookup_t     i_lookup,
    output ccu_pkg::ccu_lookup_rsp_t o_lookup_rsp,
    output ccu_pkg::ccu_fill_t       o_fill,

    // Wishbone master
    output ccu_pkg::ccu_wb_m2s_t     o_wb,
    input  ccu_pkg::ccu_wb_s2m_t     i_wb
);

    ccu_pkg::ccu_biu_req_t biu_req;
    ccu_pkg::ccu_biu_rsp_t biu_rsp;

    ccu_mhq i_mhq (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_lookup     (i_lookup),
        .o_lookup_rsp (o_lookup_rsp),
        .o_fill       (o_fill),
        .o_biu_req    (biu_req),
        .i_biu_rsp    (biu_rsp)
    );

    ccu_biu_wb i_biu_wb (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_biu_req    (biu_req),
        .o_biu_rsp    (biu_rsp),
        .o_wb         (o_wb),
        .i_wb         (i_wb)
    );

endmodule

// File: bench/ccu_wb_slave.sv
`timescale 1ns/1ps
// ********************
// Wishbone memory model for the bench
// Answers byte address A with A[15:0] ^ A5C3 after a few random waits
// and counts every burst format violation it sees
// ********************
`include "ccu_config.svh"

module ccu_wb_slave (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  ccu_pkg::ccu_wb_m2s_t i_wb,
    output ccu_pkg::ccu_wb_s2m_t o_wb,
    output int                   o_violations
);

    logic                          ack_q;
    logic [`CCU_WB_DATA_WIDTH-1:0] data_q;
    logic                          busy_q;
    logic [1:0]                    wait_q;
    logic [31:0]                   rnd_q;
    logic [31:0]                   rnd_n;
    logic [2:0]                    beat_q;
    logic [`CCU_ADDR_WIDTH-1:0]    base_q;
    int                            violations = 0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic report_violation(input string what);
        violations++;
        $display("Wishbone violation at %0t ns: %s on beat %0d", $time, what, beat_q);
    endtask

    assign rnd_n = xorshift(rnd_q);

    // ********************
    // Wait states and read data
    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q  <= 1'b0;
            data_q <= '0;
            busy_q <= 1'b0;
            wait_q <= '0;
            rnd_q  <= 32'd47450;
        end else begin
            ack_q <= 1'b0;                                   // One beat per ack
            if (i_wb.cyc && i_wb.stb && !ack_q) begin
                if (!busy_q) begin
                    rnd_q  <= rnd_n;
                    wait_q <= rnd_n[1:0];
                    busy_q <= 1'b1;
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 1'b1;
                end else begin
                    ack_q  <= 1'b1;
                    data_q <= i_wb.addr[15:0] ^ 16'hA5C3;
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // ********************
    // Burst format checks
    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            beat_q <= '0;
            base_q <= '0;
        end else begin
            if (i_wb.stb && !i_wb.cyc) report_violation("stb without cyc");
            if (!i_wb.cyc && beat_q != 3'd0) report_violation("burst ended early");
            if (i_wb.cyc && i_wb.stb && ack_q) begin
                if (beat_q == 3'd0 && i_wb.addr[3:0] != 4'h0) begin
                    report_violation("line address not aligned");
                end
                if (beat_q != 3'd0 && i_wb.addr != base_q + 32'(beat_q) * 2) begin
                    report_violation("address not incrementing");
                end
                if (i_wb.sel != 2'b11 || i_wb.we) report_violation("not a full read");
                if (i_wb.cti != ((beat_q == 3'(`CCU_WB_BEATS - 1)) ? ccu_pkg::CTI_END
                                                                  : ccu_pkg::CTI_INCR)) begin
                    report_violation("wrong cti");
                end
                if (i_wb.bte != ccu_pkg::BTE_LINEAR) report_violation("wrong bte");
                if (beat_q == 3'd0) base_q <= i_wb.addr;
                beat_q <= beat_q + 1'b1;                     // Wraps after beat 7
            end
        end
    end

    assign o_wb         = '{ack: ack_q, data: data_q};
    assign o_violations = violations;

endmodule

// File: bench/ccu_tb.sv
`timescale 1ns/1ps
// ********************
// Testbench for the communications unit
// Plays a table of lookups, predicts each fill from a line model
// and checks the burst count of errors kept by the memory model
// ********************
`include "ccu_config.svh"

module ccu_tb;

    localparam int PERIOD    = 40;
    localparam int DEPTH     = `CCU_MHQ_DEPTH;
    localparam int LINE_SIZE = `CCU_LINE_SIZE;
    localparam int LINE_W    = `CCU_LINE_WIDTH;
    localparam int IDLE_TAIL = 48;                       // Room for a stray fill

    typedef struct packed {
        logic [3:0]                    test;
        logic [2:0]                    wait_n;           // Fills of this test to await first
        logic                          valid;
        logic                          dc_hit;
        logic [`CCU_ADDR_WIDTH-1:0]    addr;
        ccu_pkg::ccu_op_e              op;
        logic [`CCU_DATA_WIDTH-1:0]    data;
        logic                          retry;
        logic                          replay;
        logic [`CCU_MHQ_IDX_WIDTH-1:0] tag;
    } row_t;

    logic                       clk = 1'b0;
    logic                       arst_n;
    ccu_pkg::ccu_lookup_t       lookup;
    ccu_pkg::ccu_lookup_rsp_t   lookup_rsp;
    ccu_pkg::ccu_fill_t         fill;
    ccu_pkg::ccu_wb_m2s_t       wb_m2s;
    ccu_pkg::ccu_wb_s2m_t       wb_s2m;
    int                         wb_violations;

    row_t                       rows [$];
    int                         n_rows = 0;
    string                      test_names [6] = '{"load miss", "store miss", "merge",
                                                   "queue full", "hit and idle", "burst format"};

    // ********************
    // Line model
    logic [DEPTH-1:0]           m_valid = '0;
    logic [DEPTH-1:0]           m_dirty;
    logic [`CCU_ADDR_WIDTH-1:0] m_addr [DEPTH];
    logic [LINE_SIZE-1:0]       m_mask [DEPTH];
    logic [LINE_W-1:0]          m_line [DEPTH];
    int                         m_age [$];                // Allocation order

    int pass_count      = 0;
    int error_count     = 0;
    int errors_at_start = 0;
    int fills_in_test   = 0;

    always #(PERIOD / 2) clk = ~clk;

    ccu_top i_ccu_top (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .i_lookup     (lookup),
        .o_lookup_rsp (lookup_rsp),
        .o_fill       (fill),
        .o_wb         (wb_m2s),
        .i_wb         (wb_s2m)
    );

    ccu_wb_slave i_ccu_wb_slave (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .i_wb         (wb_m2s),
        .o_wb         (wb_s2m),
        .o_violations (wb_violations)
    );

    task automatic compare_value(input string name, input logic [LINE_W-1:0] exp,
                                 input logic [LINE_W-1:0] act);
        if (exp !== act) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        end else begin
            pass_count++;
        end
    endtask

    task automatic add_row(input int test, input int wait_n, input logic valid,
                           input logic dc_hit, input logic [31:0] addr, input ccu_pkg::ccu_op_e op,
                           input logic [31:0] data, input logic retry, input logic replay,
                           input logic [1:0] tag);
        row_t r;
        r = '{test: 4'(test), wait_n: 3'(wait_n), valid: valid, dc_hit: dc_hit, addr: addr,
              op: op, data: data, retry: retry, replay: replay, tag: tag};
        rows.push_back(r);
        n_rows++;
    endtask

    function automatic logic [LINE_W-1:0] pattern_line(input logic [31:0] line_addr);
        logic [LINE_W-1:0] line;
        logic [31:0]       a;
        for (int k = 0; k < `CCU_WB_BEATS; k++) begin
            a = line_addr + 32'(2 * k);
            line[16*k +: 16] = a[15:0] ^ 16'hA5C3;
        end
        return line;
    endfunction

    function automatic int store_bytes(input ccu_pkg::ccu_op_e op);
        case (op)
            ccu_pkg::OP_SB: return 1;
            ccu_pkg::OP_SH: return 2;
            ccu_pkg::OP_SW: return 4;
            default:        return 0;
        endcase
    endfunction

    task automatic model_lookup(input row_t r);
        logic [31:0] line;
        int          idx;
        int          nbytes;
        int          off;
        if (!r.valid || r.dc_hit) return;
        line = {r.addr[31:4], 4'h0};
        idx  = -1;
        for (int e = DEPTH - 1; e >= 0; e--) if (m_valid[e] && m_addr[e] == line) idx = e;
        if (idx < 0) begin
            for (int e = DEPTH - 1; e >= 0; e--) if (!m_valid[e]) idx = e;
            if (idx < 0) return;                             // Full so the lookup is retried
            m_valid[idx] = 1'b1;
            m_dirty[idx] = 1'b0;
            m_addr[idx]  = line;
            m_mask[idx]  = '0;
            m_age.push_back(idx);
        end
        nbytes = store_bytes(r.op);
        off    = r.addr[3:0];
        for (int b = 0; b < nbytes; b++) begin
            m_line[idx][8*(off+b) +: 8] = r.data[8*b +: 8];
            m_mask[idx][off+b]          = 1'b1;
        end
        if (nbytes != 0) m_dirty[idx] = 1'b1;
    endtask

    task automatic collect_fill();
        int                idx;
        logic [LINE_W-1:0] exp_data;
        if (!fill.en) return;
        if (m_age.size() == 0) begin
            error_count++;
            $display("Fill at %0t ns for line %h arrived with no line pending", $time, fill.addr);
            return;
        end
        idx      = m_age.pop_front();
        exp_data = pattern_line(m_addr[idx]);
        for (int b = 0; b < LINE_SIZE; b++) begin
            if (m_mask[idx][b]) exp_data[8*b +: 8] = m_line[idx][8*b +: 8];
        end
        compare_value("o_fill.tag", idx, fill.tag);
        compare_value("o_fill.dirty", m_dirty[idx], fill.dirty);
        compare_value("o_fill.addr", m_addr[idx], fill.addr);
        compare_value("o_fill.data", exp_data, fill.data);
        m_valid[idx] = 1'b0;
        fills_in_test++;
    endtask

    task automatic step_cycle();
        @(negedge clk);
        collect_fill();
    endtask

    task automatic apply_row(input row_t r);
        while (fills_in_test < r.wait_n) step_cycle();
        lookup = '{valid: r.valid, dc_hit: r.dc_hit, addr: r.addr, op: r.op, data: r.data};
        model_lookup(r);
        step_cycle();                                        // Response one cycle later
        compare_value("o_lookup_rsp.retry", r.retry, lookup_rsp.retry);
        compare_value("o_lookup_rsp.replay", r.replay, lookup_rsp.replay);
        compare_value("o_lookup_rsp.tag", r.tag, lookup_rsp.tag);
        lookup = '0;
    endtask

    task automatic report_test(input int id);
        $display("Test %0d (%s) finished with %0d errors", id, test_names[id-1],
                 error_count - errors_at_start);
        errors_at_start = error_count;
        fills_in_test   = 0;
    endtask

    task automatic finish_test(input int id);
        while (m_age.size() != 0) step_cycle();
        repeat (IDLE_TAIL) step_cycle();
        report_test(id);
    endtask

    initial begin
        int cur_test;
        arst_n = 1'b0;
        lookup = '0;
        // test wait valid hit address op data retry replay tag
        add_row(1, 0, 1, 0, 32'h0000_1004, ccu_pkg::OP_LW, 32'h0000_0000, 0, 1, 0);
        add_row(2, 0, 1, 0, 32'h0000_2005, ccu_pkg::OP_SB, 32'h0000_005A, 0, 0, 0);
        add_row(2, 0, 1, 0, 32'h0000_2106, ccu_pkg::OP_SH, 32'h0000_BEEF, 0, 0, 1);
        add_row(2, 0, 1, 0, 32'h0000_2208, ccu_pkg::OP_SW, 32'h1234_5678, 0, 0, 2);
        add_row(3, 0, 1, 0, 32'h0000_3002, ccu_pkg::OP_LH, 32'h0000_0000, 0, 1, 0);
        add_row(3, 0, 1, 0, 32'h0000_300C, ccu_pkg::OP_SW, 32'hCAFE_F00D, 0, 0, 0);
        add_row(3, 0, 1, 0, 32'h0000_3001, ccu_pkg::OP_SB, 32'h0000_0077, 0, 0, 0);
        add_row(3, 0, 1, 0, 32'h0000_300F, ccu_pkg::OP_LB, 32'h0000_0000, 0, 1, 0);
        add_row(4, 0, 1, 0, 32'h0000_4000, ccu_pkg::OP_LW, 32'h0000_0000, 0, 1, 0);
        add_row(4, 0, 1, 0, 32'h0000_4010, ccu_pkg::OP_LW, 32'h0000_0000, 0, 1, 1);
        add_row(4, 0, 1, 0, 32'h0000_4020, ccu_pkg::OP_LW, 32'h0000_0000, 0, 1, 2);
        add_row(4, 0, 1, 0, 32'h0000_4030, ccu_pkg::OP_LW, 32'h0000_0000, 0, 1, 3);
        add_row(4, 0, 1, 0, 32'h0000_4040, ccu_pkg::OP_LW, 32'h0000_0000, 1, 0, 0);
        add_row(4, 1, 1, 0, 32'h0000_4040, ccu_pkg::OP_LW, 32'h0000_0000, 0, 1, 0);
        add_row(5, 0, 1, 1, 32'h0000_5000, ccu_pkg::OP_LW, 32'h0000_0000, 0, 0, 0);
        add_row(5, 0, 0, 0, 32'h0000_5010, ccu_pkg::OP_SW, 32'h1111_2222, 0, 0, 0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n   = 1'b1;
        cur_test = rows[0].test;
        foreach (rows[i]) begin
            if (rows[i].test != cur_test) begin
                finish_test(cur_test);
                cur_test = rows[i].test;
            end
            apply_row(rows[i]);
        end
        finish_test(cur_test);
        compare_value("wb_violations", 0, wb_violations);
        report_test(6);
        $display("Summary: %0d checks passed, %0d errors", pass_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (n_rows != 0);
        #(n_rows * `CCU_WB_BEATS * 4 * PERIOD + 400 * PERIOD);
        $display("Watchdog timeout at %0t ns, fills still outstanding", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: ccu_top.f
+incdir+source
source/ccu_pkg.sv
source/ccu_mhq.sv
source/ccu_biu_wb.sv
source/ccu_top.sv
bench/ccu_wb_slave.sv
bench/ccu_tb.sv
